// File: rtl/usiPkg.sv
`default_nettype none

package usiPkg;

    // ------------------------------
    // Bus geometry
    // ------------------------------
    // Data word width, four serial bytes per word
    localparam int cBusBit = 32;

    // Address split as seen by a slave
    typedef struct packed {
        logic [3:0]  slaveId;
        logic [25:0] rsvd;
        logic [1:0]  regOfs;
    } usiAdrsField_t;

    // Same address word, raw or split
    typedef union packed {
        logic [cBusBit-1:0] raw;
        usiAdrsField_t      fields;
    } usiAdrs_u;

    // Master to slave request
    typedef struct packed {
        logic [cBusBit-1:0] wd;
        usiAdrs_u           adrs;
        logic               wCke;
        logic               rCke;
    } usiReq_t;

    // Slave to master response
    typedef struct packed {
        logic [cBusBit-1:0] rd;
        logic               vd;
    } usiRsp_t;

    // ------------------------------
    // Frame commands
    // ------------------------------
    // ASCII W and R
    localparam logic [7:0] cCmdWrite = 8'h57;
    localparam logic [7:0] cCmdRead  = 8'h52;

    // GPIO register map
    localparam logic [1:0] cRegLedEdge = 2'd0;
    localparam logic [1:0] cRegLedDiv  = 2'd1;
    localparam logic [1:0] cRegScratch = 2'd2;
    localparam logic [1:0] cRegId      = 2'd3;

endpackage

`default_nettype wire

// File: rtl/uartRx.sv
`timescale 1ns/1ps
`default_nettype none

module uartRx #(
    parameter int pClkPerBit = 434
)(
    input  wire        sysClk,
    input  wire        rst,
    input  wire        rx,
    output logic [7:0] rxData,
    output logic       rxVd
);

    localparam int                 cCntBit  = $clog2(pClkPerBit);
    localparam logic [cCntBit-1:0] cBitEnd  = cCntBit'(pClkPerBit - 1);
    localparam logic [cCntBit-1:0] cHalfBit = cCntBit'(pClkPerBit / 2);

    typedef enum logic [1:0] {sIdle, sStart, sData, sStop} rxState_t;

    rxState_t           state;
    logic [1:0]         rxSync;
    logic [cCntBit-1:0] bitTimer;
    logic [2:0]         bitCnt;

    // Two-stage synchronizer, line idles high
    always_ff @(posedge sysClk)
    begin
        if (rst)
            rxSync <= 2'b11;
        else
            rxSync <= {rxSync[0], rx};
    end

    // ------------------------------
    // Bit timing FSM
    // ------------------------------
    always_ff @(posedge sysClk)
    begin
        if (rst)
        begin
            state    <= sIdle;
            bitTimer <= '0;
            bitCnt   <= '0;
            rxVd     <= 1'b0;
        end
        else
        begin
            rxVd <= 1'b0;
            case (state)
                sIdle:
                begin
                    bitTimer <= '0;
                    bitCnt   <= '0;
                    // Falling edge marks a start bit
                    if (!rxSync[1])
                        state <= sStart;
                end
                sStart:
                begin
                    if (bitTimer == cHalfBit)
                    begin
                        bitTimer <= '0;
                        // Glitch shorter than half a bit
                        state    <= rxSync[1] ? sIdle : sData;
                    end
                    else
                        bitTimer <= bitTimer + 1'b1;
                end
                sData:
                begin
                    if (bitTimer == cBitEnd)
                    begin
                        bitTimer <= '0;
                        bitCnt   <= bitCnt + 1'b1;
                        if (bitCnt == 3'd7)
                            state <= sStop;
                    end
                    else
                        bitTimer <= bitTimer + 1'b1;
                end
                sStop:
                begin
                    if (bitTimer == cBitEnd)
                    begin
                        // Bad stop bit drops the byte
                        rxVd  <= rxSync[1];
                        state <= sIdle;
                    end
                    else
                        bitTimer <= bitTimer + 1'b1;
                end
                default:
                    state <= sIdle;
            endcase
        end
    end

    // LSB first, sampled mid bit
    always_ff @(posedge sysClk)
    begin
        if (state == sData && bitTimer == cBitEnd)
            rxData <= {rxSync[1], rxData[7:1]};
    end

endmodule

`default_nettype wire

// File: rtl/uartTx.sv
`timescale 1ns/1ps
`default_nettype none

module uartTx #(
    parameter int pClkPerBit = 434
)(
    input  wire        sysClk,
    input  wire        rst,
    input  wire        txStart,
    input  wire  [7:0] txData,
    output logic       tx,
    output logic       txBusy
);

    localparam int                 cCntBit = $clog2(pClkPerBit);
    localparam logic [cCntBit-1:0] cBitEnd = cCntBit'(pClkPerBit - 1);

    logic [cCntBit-1:0] bitTimer;
    // Start is bit 0, stop is bit 9
    logic [3:0]         bitCnt;
    // Data bits with the stop bit on top
    logic [8:0]         shiftReg;

    // ------------------------------
    // Frame sequencing
    // ------------------------------
    always_ff @(posedge sysClk)
    begin
        if (rst)
        begin
            tx       <= 1'b1;
            txBusy   <= 1'b0;
            bitTimer <= '0;
            bitCnt   <= '0;
        end
        else if (!txBusy)
        begin
            bitTimer <= '0;
            bitCnt   <= '0;
            if (txStart)
            begin
                // Start bit goes out at once
                txBusy <= 1'b1;
                tx     <= 1'b0;
            end
        end
        else if (bitTimer != cBitEnd)
            bitTimer <= bitTimer + 1'b1;
        else
        begin
            bitTimer <= '0;
            bitCnt   <= bitCnt + 1'b1;
            // End of stop bit
            if (bitCnt == 4'd9)
                txBusy <= 1'b0;
            else
                tx <= shiftReg[0];
        end
    end

    // Shifts in ones, so the stop bit follows d7
    always_ff @(posedge sysClk)
    begin
        if (!txBusy && txStart)
            shiftReg <= {1'b1, txData};
        else if (txBusy && bitTimer == cBitEnd)
            shiftReg <= {1'b1, shiftReg[8:1]};
    end

endmodule

`default_nettype wire

// File: rtl/microControllerBlock.sv
`timescale 1ns/1ps
`default_nettype none

module microControllerBlock import usiPkg::*; #(
    parameter int pClkPerBit = 434
)(
    input  wire          sysClk,
    input  wire          rst,
    input  wire          uartRx,
    output wire          uartTx,
    output usiReq_t      mReq,
    input  wire usiRsp_t mRsp
);

    typedef enum logic [2:0] {sIdle, sAdrs, sData, sWait, sSend} mcbState_t;

    mcbState_t          state;
    logic [7:0]         rxData;
    logic               rxVd;
    logic               txStart;
    logic [7:0]         txData;
    logic               txBusy;
    logic               txBusyD;
    logic               txDone;
    logic [1:0]         byteCnt;
    logic [1:0]         sendCnt;
    logic               isRead;
    logic               lastByte;
    usiAdrs_u           adrsReg;
    logic [cBusBit-1:0] dataReg;
    logic [cBusBit-1:0] rdShift;
    logic               wCkeReg;
    logic               rCkeReg;

    // ------------------------------
    // Serial line
    // ------------------------------
    uartRx #(
        .pClkPerBit (pClkPerBit)
    ) rxInst (
        .sysClk (sysClk),
        .rst    (rst),
        .rx     (uartRx),
        .rxData (rxData),
        .rxVd   (rxVd)
    );

    uartTx #(
        .pClkPerBit (pClkPerBit)
    ) txInst (
        .sysClk  (sysClk),
        .rst     (rst),
        .txStart (txStart),
        .txData  (txData),
        .tx      (uartTx),
        .txBusy  (txBusy)
    );

    // One answer byte finished
    assign txDone   = txBusyD && !txBusy;
    // Fourth byte of an address or data word
    assign lastByte = rxVd && (byteCnt == 2'd3);

    // Bus request straight from the frame registers
    assign mReq = '{wd: dataReg, adrs: adrsReg, wCke: wCkeReg, rCke: rCkeReg};

    // ------------------------------
    // Frame parser FSM
    // ------------------------------
    always_ff @(posedge sysClk)
    begin
        if (rst)
        begin
            state   <= sIdle;
            byteCnt <= '0;
            sendCnt <= '0;
            isRead  <= 1'b0;
            wCkeReg <= 1'b0;
            rCkeReg <= 1'b0;
            txStart <= 1'b0;
            txBusyD <= 1'b0;
        end
        else
        begin
            // Strobes are single cycle
            wCkeReg <= 1'b0;
            rCkeReg <= 1'b0;
            txStart <= 1'b0;
            txBusyD <= txBusy;
            case (state)
                sIdle:
                begin
                    byteCnt <= '0;
                    // Unknown command bytes fall through
                    if (rxVd && (rxData == cCmdWrite || rxData == cCmdRead))
                    begin
                        isRead <= (rxData == cCmdRead);
                        state  <= sAdrs;
                    end
                end
                sAdrs:
                begin
                    if (rxVd)
                        byteCnt <= byteCnt + 1'b1;
                    if (lastByte)
                    begin
                        rCkeReg <= isRead;
                        state   <= isRead ? sWait : sData;
                    end
                end
                sData:
                begin
                    if (rxVd)
                        byteCnt <= byteCnt + 1'b1;
                    if (lastByte)
                    begin
                        wCkeReg <= 1'b1;
                        state   <= sIdle;
                    end
                end
                // Received bytes ignored until the answer is out
                sWait:
                begin
                    if (mRsp.vd)
                    begin
                        txStart <= 1'b1;
                        sendCnt <= '0;
                        state   <= sSend;
                    end
                end
                sSend:
                begin
                    if (txDone)
                    begin
                        if (sendCnt == 2'd3)
                            state <= sIdle;
                        else
                        begin
                            sendCnt <= sendCnt + 1'b1;
                            txStart <= 1'b1;
                        end
                    end
                end
                default:
                    state <= sIdle;
            endcase
        end
    end

    // Word assembly and answer shifting, MSB first
    always_ff @(posedge sysClk)
    begin
        if (rxVd && state == sAdrs)
            adrsReg.raw <= {adrsReg.raw[cBusBit-9:0], rxData};
        if (rxVd && state == sData)
            dataReg <= {dataReg[cBusBit-9:0], rxData};
        if (state == sWait && mRsp.vd)
        begin
            txData  <= mRsp.rd[cBusBit-1:cBusBit-8];
            rdShift <= {mRsp.rd[cBusBit-9:0], 8'h00};
        end
        else if (state == sSend && txDone)
        begin
            txData  <= rdShift[cBusBit-1:cBusBit-8];
            rdShift <= {rdShift[cBusBit-9:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

// File: rtl/usiBus.sv
`timescale 1ns/1ps
`default_nettype none

module usiBus import usiPkg::*; #(
    parameter int pBusNum = 2
)(
    input  wire          sysClk,
    input  wire          rst,
    input  wire usiReq_t mReq,
    output usiRsp_t      mRsp,
    output usiReq_t      sReq [pBusNum],
    input  wire usiRsp_t sRsp [pBusNum]
);

    logic [cBusBit-1:0] reqWd;
    usiAdrs_u           reqAdrs;
    logic               reqWCke;
    logic               reqRCke;
    logic               reqInRange;
    logic [3:0]         selId;
    logic               oorRd;
    usiRsp_t            selRsp;

    // ------------------------------
    // Request stage
    // ------------------------------
    always_ff @(posedge sysClk)
    begin
        reqWd   <= mReq.wd;
        reqAdrs <= mReq.adrs;
    end

    always_ff @(posedge sysClk)
    begin
        if (rst)
        begin
            reqWCke <= 1'b0;
            reqRCke <= 1'b0;
        end
        else
        begin
            reqWCke <= mReq.wCke;
            reqRCke <= mReq.rCke;
        end
    end

    assign reqInRange = int'(reqAdrs.fields.slaveId) < pBusNum;

    // Payload to all, strobes only to the addressed slave
    always_comb
    begin
        for (int i = 0; i < pBusNum; i++)
        begin
            sReq[i].wd   = reqWd;
            sReq[i].adrs = reqAdrs;
            sReq[i].wCke = reqWCke && (reqAdrs.fields.slaveId == 4'(i));
            sReq[i].rCke = reqRCke && (reqAdrs.fields.slaveId == 4'(i));
        end
    end

    // ------------------------------
    // Response stage
    // ------------------------------
    // Slave id follows the request to the answer cycle
    always_ff @(posedge sysClk)
    begin
        if (rst)
        begin
            selId <= '0;
            oorRd <= 1'b0;
        end
        else
        begin
            selId <= reqAdrs.fields.slaveId;
            // No slave there, answer locally
            oorRd <= reqRCke && !reqInRange;
        end
    end

    // Out of range id selects nothing, so rd stays zero
    always_comb
    begin
        selRsp = '0;
        for (int i = 0; i < pBusNum; i++)
        begin
            if (selId == 4'(i))
                selRsp = sRsp[i];
        end
    end

    always_ff @(posedge sysClk)
    begin
        if (rst)
            mRsp <= '0;
        else
            mRsp <= '{rd: selRsp.rd, vd: selRsp.vd | oorRd};
    end

endmodule

`default_nettype wire

// File: rtl/gpioBlock.sv
`timescale 1ns/1ps
`default_nettype none

module gpioBlock import usiPkg::*; #(
    parameter int pSlaveId = 0
)(
    input  wire          sysClk,
    input  wire          rst,
    input  wire usiReq_t sReq,
    output usiRsp_t      sRsp,
    output logic [1:0]   ledEdge,
    output logic         ledClk
);

    logic [1:0]         regOfs;
    logic [1:0]         edgeReg;
    logic [cBusBit-1:0] divReg;
    logic [cBusBit-1:0] scratchReg;
    logic [cBusBit-1:0] divCnt;

    // Slave only looks at the low address bits
    assign regOfs  = sReq.adrs.fields.regOfs;
    assign ledEdge = edgeReg;

    // ------------------------------
    // Register writes
    // ------------------------------
    always_ff @(posedge sysClk)
    begin
        if (rst)
        begin
            edgeReg    <= '0;
            divReg     <= '0;
            scratchReg <= '0;
        end
        else if (sReq.wCke)
        begin
            case (regOfs)
                cRegLedEdge: edgeReg    <= sReq.wd[1:0];
                cRegLedDiv:  divReg     <= sReq.wd;
                cRegScratch: scratchReg <= sReq.wd;
                // Identity is read only
                default:     ;
            endcase
        end
    end

    // Read answer one cycle after rCke
    always_ff @(posedge sysClk)
    begin
        if (rst)
            sRsp <= '0;
        else
        begin
            sRsp.vd <= sReq.rCke;
            if (sReq.rCke)
            begin
                case (regOfs)
                    cRegLedEdge: sRsp.rd <= cBusBit'(edgeReg);
                    cRegLedDiv:  sRsp.rd <= divReg;
                    cRegScratch: sRsp.rd <= scratchReg;
                    default:     sRsp.rd <= cBusBit'(pSlaveId);
                endcase
            end
        end
    end

    // ------------------------------
    // LED clock divider
    // ------------------------------
    // Half period is divReg plus 1 cycles
    always_ff @(posedge sysClk)
    begin
        if (rst)
        begin
            divCnt <= '0;
            ledClk <= 1'b0;
        end
        else if (divReg == '0)
        begin
            // Divider off, LED held low
            divCnt <= '0;
            ledClk <= 1'b0;
        end
        else if (divCnt >= divReg)
        begin
            // Also catches a shrunk divider
            divCnt <= '0;
            ledClk <= !ledClk;
        end
        else
            divCnt <= divCnt + 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/processor.sv
`timescale 1ns/1ps
`default_nettype none

module processor import usiPkg::*; #(
    parameter int pBusNum    = 2,
    parameter int pClkPerBit = 434
)(
    input  wire                   sysClk,
    input  wire                   rst,
    input  wire                   uartRx,
    output wire                   uartTx,
    output wire [2*pBusNum-1:0]   ledEdge,
    output wire [pBusNum-1:0]     ledClk
);

    // Master side of the bus
    usiReq_t mReq;
    usiRsp_t mRsp;
    // Slave side, one entry per GPIO block
    usiReq_t sReq [pBusNum];
    usiRsp_t sRsp [pBusNum];

    // ------------------------------
    // Bus master
    // ------------------------------
    microControllerBlock #(
        .pClkPerBit (pClkPerBit)
    ) mcbInst (
        .sysClk (sysClk),
        .rst    (rst),
        .uartRx (uartRx),
        .uartTx (uartTx),
        .mReq   (mReq),
        .mRsp   (mRsp)
    );

    // Registered interconnect
    usiBus #(
        .pBusNum (pBusNum)
    ) busInst (
        .sysClk (sysClk),
        .rst    (rst),
        .mReq   (mReq),
        .mRsp   (mRsp),
        .sReq   (sReq),
        .sRsp   (sRsp)
    );

    // ------------------------------
    // GPIO slaves
    // ------------------------------
    // Slave number equals bus port index
    for (genvar i = 0; i < pBusNum; i++)
    begin : genGpio
        gpioBlock #(
            .pSlaveId (i)
        ) gpioInst (
            .sysClk  (sysClk),
            .rst     (rst),
            .sReq    (sReq[i]),
            .sRsp    (sRsp[i]),
            .ledEdge (ledEdge[2*i +: 2]),
            .ledClk  (ledClk[i])
        );
    end

endmodule

`default_nettype wire

// File: dv/usiBusChk.sv
`timescale 1ns/1ps
`default_nettype none

module usiBusChk import usiPkg::*; (
    input wire          sysClk,
    input wire          rst,
    input wire usiReq_t mReq,
    input wire usiRsp_t mRsp,
    input wire          reqWCke,
    input wire          reqRCke,
    input wire          uartTx
);

    // ------------------------------
    // Bus timing
    // ------------------------------
    // Answer lands exactly 3 cycles after rCke, not earlier
    property pReadLatency;
        @(posedge sysClk) disable iff (rst)
        mReq.rCke |-> ##1 !mRsp.vd ##1 !mRsp.vd ##1 mRsp.vd;
    endproperty

    aReadLatency: assert property (pReadLatency)
        else $error("read valid not seen 3 cycles after rCke");

    // One strobe kind per cycle
    aStrobeExcl: assert property (@(posedge sysClk) disable iff (rst)
        !(mReq.wCke && mReq.rCke))
        else $error("wCke and rCke high in the same cycle");

    // ------------------------------
    // Reset state
    // ------------------------------
    // Second reset cycle onward, registers already cleared
    property pResetQuiet;
        @(posedge sysClk)
        (rst ##1 rst) |-> (uartTx && !mReq.wCke && !mReq.rCke && !reqWCke && !reqRCke
                           && !mRsp.vd);
    endproperty

    aResetQuiet: assert property (pResetQuiet)
        else $error("strobe active or serial line low during reset");

endmodule

`default_nettype wire

// File: dv/tbProcessor.sv
`timescale 1ns/1ps
`default_nettype none

module tbProcessor import usiPkg::*; ();

    localparam int cBusNum    = 2;
    localparam int cClkPerBit = 16;
    localparam int cClkNs     = 40;
    // Every bus access costs 9 UART frames with its answer
    localparam int cUartFrames = 9*4 + 9*2 + 9*4 + 9*2 + 9*4 + (1 + 9*7 + 2 + 9*2);
    localparam int cWatchdogNs = 2 * cUartFrames * 10 * cClkPerBit * cClkNs;
    // Read frame plus some slack before the answer must start
    localparam int cRecvWait   = 6 * 10 * cClkPerBit;

    logic                 sysClk;
    logic                 rst;
    logic                 uartRx;
    wire                  uartTx;
    wire [2*cBusNum-1:0]  ledEdge;
    wire [cBusNum-1:0]    ledClk;

    int                   errCnt;
    int                   checkCnt;
    int                   testCnt;
    // Last word written to each scratch register
    logic [cBusBit-1:0]   scratchVal [cBusNum];

    processor #(
        .pBusNum    (cBusNum),
        .pClkPerBit (cClkPerBit)
    ) dut_i (
        .sysClk  (sysClk),
        .rst     (rst),
        .uartRx  (uartRx),
        .uartTx  (uartTx),
        .ledEdge (ledEdge),
        .ledClk  (ledClk)
    );

    bind usiBus usiBusChk chkInst (
        .sysClk  (sysClk),
        .rst     (rst),
        .mReq    (mReq),
        .mRsp    (mRsp),
        .reqWCke (reqWCke),
        .reqRCke (reqRCke),
        .uartTx  (tbProcessor.dut_i.uartTx)
    );

    initial
    begin
        sysClk = 1'b0;
        forever #(cClkNs/2) sysClk = ~sysClk;
    end

    // ------------------------------
    // Host side of the serial line
    // ------------------------------
    // Start bit, 8 data bits LSB first, stop bit
    task automatic sendByte(input logic [7:0] value);
        logic [9:0] bits;
        bits = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(negedge sysClk);
            uartRx = bits[i];
            repeat (cClkPerBit - 1) @(negedge sysClk);
        end
    endtask

    // Command, address, then data for a write; MSB first
    task automatic sendFrame(input logic [7:0] cmd, input logic [cBusBit-1:0] adrs,
                             input logic [cBusBit-1:0] data, input bit withData);
        sendByte(cmd);
        for (int i = 3; i >= 0; i--)
            sendByte(adrs[8*i +: 8]);
        if (withData)
        begin
            for (int i = 3; i >= 0; i--)
                sendByte(data[8*i +: 8]);
        end
    endtask

    // Four answer bytes sampled in the middle of each bit
    task automatic recvWord(output logic [cBusBit-1:0] word);
        logic [7:0] value;
        int         waitCnt;
        word = '0;
        for (int b = 0; b < 4; b++)
        begin
            waitCnt = 0;
            @(negedge sysClk);
            while (uartTx !== 1'b0 && waitCnt < cRecvWait)
            begin
                @(negedge sysClk);
                waitCnt++;
            end
            if (uartTx !== 1'b0)
            begin
                $display("Answer byte %0d never started on uartTx at %0t", b, $time);
                errCnt++;
                return;
            end
            repeat (cClkPerBit/2) @(negedge sysClk);
            for (int i = 0; i < 8; i++)
            begin
                repeat (cClkPerBit) @(negedge sysClk);
                value[i] = uartTx;
            end
            repeat (cClkPerBit) @(negedge sysClk);
            if (uartTx !== 1'b1)
            begin
                $display("Answer byte %0d has a low stop bit at %0t", b, $time);
                errCnt++;
            end
            word = {word[cBusBit-9:0], value};
        end
    endtask

    // Random reserved bits that the decode must ignore
    function automatic usiAdrs_u makeAdrs(input int slave, input logic [1:0] ofs);
        usiAdrs_u adrs;
        adrs.raw            = $urandom;
        adrs.fields.slaveId = 4'(slave);
        adrs.fields.regOfs  = ofs;
        return adrs;
    endfunction

    task automatic writeReg(input int slave, input logic [1:0] ofs,
                            input logic [cBusBit-1:0] data);
        usiAdrs_u adrs;
        adrs = makeAdrs(slave, ofs);
        sendFrame(cCmdWrite, adrs.raw, data, 1'b1);
        repeat (4) @(negedge sysClk);
    endtask

    // Answer may start before the last frame byte ends
    task automatic readReg(input int slave, input logic [1:0] ofs,
                           output logic [cBusBit-1:0] word);
        usiAdrs_u adrs;
        adrs = makeAdrs(slave, ofs);
        fork
            sendFrame(cCmdRead, adrs.raw, '0, 1'b0);
            recvWord(word);
        join
        repeat (4) @(negedge sysClk);
    endtask

    // Counts negedges until the pin changes or the limit is hit
    task automatic edgeGap(input int n, input int limit, output int cycles);
        logic level;
        level  = ledClk[n];
        cycles = 0;
        do
        begin
            @(negedge sysClk);
            cycles++;
        end
        while (ledClk[n] === level && cycles < limit);
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic checkWord(input logic [cBusBit-1:0] expWord,
                             input logic [cBusBit-1:0] actWord, input string msg);
        checkCnt++;
        if (actWord !== expWord)
        begin
            $display("CHECK FAILED at %0t: %s, expected %h, got %h",
                     $time, msg, expWord, actWord);
            errCnt++;
        end
    endtask

    task automatic checkLed(input logic [1:0] expLed, input logic [1:0] actLed,
                            input string msg);
        checkCnt++;
        if (actLed !== expLed)
        begin
            $display("CHECK FAILED at %0t: %s, expected %b, got %b",
                     $time, msg, expLed, actLed);
            errCnt++;
        end
    endtask

    task automatic checkCycles(input int expCnt, input int actCnt, input string msg);
        checkCnt++;
        if (actCnt != expCnt)
        begin
            $display("CHECK FAILED at %0t: %s, expected %0d, got %0d",
                     $time, msg, expCnt, actCnt);
            errCnt++;
        end
    endtask

    task automatic reportTest(input string name);
        testCnt++;
        $display("%-16s finished, %0d errors so far", name, errCnt);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic testScratch();
        logic [cBusBit-1:0] word;
        for (int n = 0; n < cBusNum; n++)
        begin
            scratchVal[n] = $urandom;
            writeReg(n, cRegScratch, scratchVal[n]);
        end
        for (int n = 0; n < cBusNum; n++)
        begin
            readReg(n, cRegScratch, word);
            checkWord(scratchVal[n], word, $sformatf("scratch of slave %0d", n));
        end
        reportTest("scratch");
    endtask

    task automatic testIdentity();
        logic [cBusBit-1:0] word;
        for (int n = 0; n < cBusNum; n++)
        begin
            readReg(n, cRegId, word);
            checkWord(cBusBit'(n), word, $sformatf("identity of slave %0d", n));
        end
        reportTest("identity");
    endtask

    task automatic testLedEdge();
        logic [cBusBit-1:0] word;
        logic [cBusBit-1:0] data;
        logic [1:0]         otherLed;
        int                 other;
        for (int n = 0; n < cBusNum; n++)
        begin
            other    = 1 - n;
            otherLed = ledEdge[2*other +: 2];
            // Random upper bits and low bits that flip every pin
            data      = $urandom;
            data[1:0] = ~ledEdge[2*n +: 2];
            writeReg(n, cRegLedEdge, data);
            checkLed(data[1:0], ledEdge[2*n +: 2], $sformatf("ledEdge of slave %0d", n));
            checkLed(otherLed, ledEdge[2*other +: 2], "ledEdge of the other slave");
            readReg(n, cRegLedEdge, word);
            checkWord(cBusBit'(data[1:0]), word, $sformatf("edge readback of slave %0d", n));
        end
        reportTest("led edge");
    endtask

    task automatic testLedDivider();
        int divVal;
        int cycles;
        int window;
        divVal = 2 + $urandom % 6;
        window = 4 * (divVal + 1);
        writeReg(1, cRegLedDiv, cBusBit'(divVal));
        // First gap only aligns to an edge
        edgeGap(1, window, cycles);
        edgeGap(1, window, cycles);
        checkCycles(divVal + 1, cycles, "ledClk half period");
        edgeGap(1, window, cycles);
        checkCycles(divVal + 1, cycles, "ledClk next half period");
        writeReg(1, cRegLedDiv, '0);
        checkCycles(0, int'(ledClk[1]), "ledClk level with divider zero");
        edgeGap(1, window, cycles);
        checkCycles(window, cycles, "cycles without a ledClk edge");
        reportTest("led divider");
    endtask

    task automatic testOutOfRange();
        logic [cBusBit-1:0] word;
        readReg(5, cRegScratch, word);
        checkWord('0, word, "read of missing slave 5");
        writeReg(5, cRegScratch, $urandom);
        for (int n = 0; n < cBusNum; n++)
        begin
            readReg(n, cRegScratch, word);
            checkWord(scratchVal[n], word, $sformatf("scratch of slave %0d after id 5", n));
        end
        reportTest("out of range");
    endtask

    task automatic testBadCmdReset();
        logic [cBusBit-1:0] word;
        int                 lowCnt;
        // ASCII X is neither W nor R
        sendByte(8'h58);
        readReg(0, cRegScratch, word);
        checkWord(scratchVal[0], word, "read after unknown command");
        // Two byte times of idle line
        lowCnt = 0;
        repeat (2 * 10 * cClkPerBit)
        begin
            @(negedge sysClk);
            if (uartTx !== 1'b1)
                lowCnt++;
        end
        checkCycles(0, lowCnt, "low cycles on uartTx after the answer");
        // Running dividers in both slaves so that reset has work to do
        for (int n = 0; n < cBusNum; n++)
            writeReg(n, cRegLedDiv, cBusBit'(n + 3));
        @(negedge sysClk);
        rst = 1'b1;
        repeat (5) @(negedge sysClk);
        rst = 1'b0;
        repeat (2) @(negedge sysClk);
        for (int n = 0; n < cBusNum; n++)
        begin
            checkLed(2'b00, ledEdge[2*n +: 2], $sformatf("ledEdge %0d after reset", n));
            checkCycles(0, int'(ledClk[n]), $sformatf("ledClk %0d after reset", n));
            readReg(n, cRegLedEdge, word);
            checkWord('0, word, $sformatf("edge of slave %0d after reset", n));
            readReg(n, cRegLedDiv, word);
            checkWord('0, word, $sformatf("divider of slave %0d after reset", n));
            readReg(n, cRegScratch, word);
            checkWord('0, word, $sformatf("scratch of slave %0d after reset", n));
        end
        reportTest("bad cmd, reset");
    endtask

    // ------------------------------
    // Sequence and watchdog
    // ------------------------------
    initial
    begin
        void'($urandom(76));
        rst      = 1'b1;
        uartRx   = 1'b1;
        errCnt   = 0;
        checkCnt = 0;
        testCnt  = 0;
        repeat (5) @(negedge sysClk);
        rst = 1'b0;
        repeat (4) @(negedge sysClk);
        testScratch();
        testIdentity();
        testLedEdge();
        testLedDivider();
        testOutOfRange();
        testBadCmdReset();
        $display("Tests %0d, checks %0d, errors %0d", testCnt, checkCnt, errCnt);
        if (errCnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        #(cWatchdogNs);
        $display("Watchdog expired after %0d ns, the tests did not complete", cWatchdogNs);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/usiPkg.sv
rtl/uartRx.sv
rtl/uartTx.sv
rtl/microControllerBlock.sv
rtl/usiBus.sv
rtl/gpioBlock.sv
rtl/processor.sv
dv/usiBusChk.sv
dv/tbProcessor.sv

// File: Bender.yml
package:
  name: usi_processor

sources:
  - files:
      - rtl/usiPkg.sv
      - rtl/uartRx.sv
      - rtl/uartTx.sv
      - rtl/microControllerBlock.sv
      - rtl/usiBus.sv
      - rtl/gpioBlock.sv
      - rtl/processor.sv
  - target: simulation
    files:
      - dv/usiBusChk.sv
      - dv/tbProcessor.sv
